/* Bender.yml */
package:
  name: k5soc

sources:
  - files:
      - verilog/usiPkg.sv
      - verilog/usiDecoder.sv
      - verilog/gpioBlock.sv
      - verilog/memWindow.sv
      - verilog/copyDma.sv
      - verilog/ufiMemory.sv
      - verilog/k5SocTop.sv
  - target: test
    files:
      - dv/k5Soc_sva.sv
      - dv/k5SocChecker.sv
      - dv/k5SocTb.sv

/* dv/k5SocChecker.sv */
module k5SocChecker #(
	parameter int pGpioWidth = 6,
	parameter int pRamWords  = 1024
) (
	input logic                  iMCLK,
	input logic                  qnARST,
	input logic                  usiReq,
	input logic                  usiAck,
	input logic [31:0]           usiRd,
	input logic [pGpioWidth-1:0] gpioOut,
	input logic [pGpioWidth-1:0] gpioOe
);

	timeunit 1ns;
	timeprecision 1ps;

	localparam int cAckLag = 3;		// Edges from sampled req to ack rise

	logic [15:0]           ramM [pRamWords];	// RAM model
	logic [pGpioWidth-1:0] outM = '0;
	logic [pGpioWidth-1:0] dirM = '0;
	int                    errCnt = 0;
	int                    checkCnt = 0;
	string                 expName;
	logic [31:0]           expVal;
	logic                  armed = 1'b0;		// Next ack carries a checked read
	int                    lag = -1;			// Edges since req sampled
	logic                  reqLast = 1'b0;
	logic                  ackLast = 1'b0;

	// --------------------
	// Model access
	// --------------------
	function automatic int wrapIndex(input logic [15:0] adrs);
		return int'(adrs) % pRamWords;
	endfunction

	function automatic logic [15:0] ramAt(input logic [15:0] adrs);
		return ramM[wrapIndex(adrs)];
	endfunction

	task automatic ramWrite(input logic [15:0] adrs, input logic [15:0] data);
		ramM[wrapIndex(adrs)] = data;
	endtask

	// Word by word, source before destination
	task automatic copyModel(input logic [15:0] src, input logic [15:0] dst, input int len);
		int i;
		for (i = 0; i < len; i++)
			ramM[wrapIndex(dst + 16'(i))] = ramM[wrapIndex(src + 16'(i))];
	endtask

	task automatic setGpioOut(input logic [pGpioWidth-1:0] val);
		outM = val;
	endtask

	task automatic setGpioDir(input logic [pGpioWidth-1:0] val);
		dirM = val;
	endtask

	task automatic expectRead(input string name, input logic [31:0] val);
		expName = name;
		expVal  = val;
		armed   = 1'b1;
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] want,
		input logic [31:0] got);
		$display("** Error [%s] expected 0x%0h actual 0x%0h at %0t", name, want, got, $time);
		errCnt++;
	endtask

	// --------------------
	// Host port monitor
	// --------------------
	task automatic checkAck();
		checkCnt++;
		if (lag - 1 != cAckLag)		// Seen one edge after it rises
			reportMismatch("host ack latency", cAckLag, lag - 1);
		lag = -1;
		if (armed)
		begin
			if (usiRd !== expVal)
				reportMismatch(expName, expVal, usiRd);
			armed = 1'b0;
		end
		if (gpioOut !== outM)
			reportMismatch("gpioOut pins", 32'(outM), 32'(gpioOut));
		if (gpioOe !== dirM)
			reportMismatch("gpioOe pins", 32'(dirM), 32'(gpioOe));
	endtask

	always @(posedge iMCLK)
	begin
		if (!qnARST)
			lag = -1;
		else
		begin
			if (usiReq && !reqLast)
				lag = 0;			// Edge that samples the request
			else if (lag >= 0)
				lag++;
			if (usiAck && !ackLast)
				checkAck();
		end
		reqLast = usiReq;
		ackLast = usiAck;
	end

	// Outputs idle when reset lets go
	always @(posedge qnARST)
	begin
		if (usiAck !== 1'b0)
			reportMismatch("usiAck after reset", 32'h0, 32'(usiAck));
		if (gpioOut !== '0)
			reportMismatch("gpioOut after reset", 32'h0, 32'(gpioOut));
		if (gpioOe !== '0)
			reportMismatch("gpioOe after reset", 32'h0, 32'(gpioOe));
	end

endmodule

/* dv/k5SocTb.sv */
module k5SocTb import usiPkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int pGpioWidth = 6;
	localparam int pRamWords  = 1024;
	localparam int cTimeout   = 64;		// Cycles per handshake phase
	localparam int cPollMax   = 200;	// Status reads per poll

	logic                  iMCLK, qnARST;
	logic                  usiReq, usiAck;
	usiCmdT                usiCmd;
	logic [31:0]           usiRd;
	logic [pGpioWidth-1:0] gpioIn, gpioOut, gpioOe;
	int                    seed;
	int                    toutCnt;		// Waits that ran out

	k5SocTop #(.pGpioWidth(pGpioWidth), .pRamWords(pRamWords)) uut (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.usiReq(usiReq),	.usiCmd(usiCmd),
		.usiAck(usiAck),	.usiRd(usiRd),
		.gpioIn(gpioIn),	.gpioOut(gpioOut),	.gpioOe(gpioOe)
	);

	k5SocChecker #(.pGpioWidth(pGpioWidth), .pRamWords(pRamWords)) uChk (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.usiReq(usiReq),	.usiAck(usiAck),	.usiRd(usiRd),
		.gpioOut(gpioOut),	.gpioOe(gpioOe)
	);

	initial
	begin
		iMCLK = 1'b0;
		forever #20 iMCLK = ~iMCLK;		// 40 ns period
	end

	// --------------------
	// Host port tasks
	// --------------------
	task automatic waitAck(input logic level);
		int n;
		n = 0;
		while (usiAck !== level && n < cTimeout)
		begin
			@(negedge iMCLK);
			n++;
		end
		if (usiAck !== level)
		begin
			$display("Timeout: usiAck did not go %0b within %0d cycles", level, cTimeout);
			toutCnt++;
		end
	endtask

	task automatic hostAccess(input logic wr, input logic [3:0] blk, input logic [7:0] ofs,
		input logic [31:0] wd, output logic [31:0] rd);
		@(negedge iMCLK);
		usiCmd.wr           = wr;
		usiCmd.adrs.fld.blk = blk;
		usiCmd.adrs.fld.rsv = 4'h0;
		usiCmd.adrs.fld.ofs = ofs;
		usiCmd.wd           = wd;
		usiReq              = 1'b1;
		waitAck(1'b1);
		rd     = usiRd;		// Valid while ack high
		usiReq = 1'b0;
		waitAck(1'b0);
	endtask

	task automatic csrWrite(input logic [3:0] blk, input logic [7:0] ofs, input logic [31:0] wd);
		logic [31:0] rd;
		hostAccess(1'b1, blk, ofs, wd, rd);
	endtask

	task automatic csrRead(input string name, input logic [3:0] blk, input logic [7:0] ofs,
		input logic [31:0] expVal);
		logic [31:0] rd;
		uChk.expectRead(name, expVal);
		hostAccess(1'b0, blk, ofs, '0, rd);
	endtask

	// Reads a status register until the masked bits match
	task automatic csrPoll(input logic [3:0] blk, input logic [7:0] ofs,
		input logic [31:0] mask, input logic [31:0] want);
		logic [31:0] rd;
		int          n;
		n = 0;
		hostAccess(1'b0, blk, ofs, '0, rd);
		while ((rd & mask) !== want && n < cPollMax)
		begin
			hostAccess(1'b0, blk, ofs, '0, rd);
			n++;
		end
		if ((rd & mask) !== want)
		begin
			$display("Timeout: block %0d offset 0x%0h never reached the awaited status", blk, ofs);
			toutCnt++;
		end
	endtask

	// --------------------
	// Memory window and DMA
	// --------------------
	task automatic winWrite(input logic [15:0] adrs, input logic [15:0] data);
		uChk.ramWrite(adrs, data);
		csrWrite(cBlkMem, cOfsMemAdrs, 32'(adrs));
		csrWrite(cBlkMem, cOfsMemWd, 32'(data));
		csrWrite(cBlkMem, cOfsMemCmd, 32'h1);		// Write
		csrPoll(cBlkMem, cOfsMemCmd, 32'h8000_0000, 32'h0);
	endtask

	task automatic winRead(input string name, input logic [15:0] adrs);
		csrWrite(cBlkMem, cOfsMemAdrs, 32'(adrs));
		csrWrite(cBlkMem, cOfsMemCmd, 32'h2);		// Read
		csrPoll(cBlkMem, cOfsMemCmd, 32'h8000_0000, 32'h0);
		csrRead(name, cBlkMem, cOfsMemRd, 32'(uChk.ramAt(adrs)));
	endtask

	task automatic dmaStart(input logic [15:0] src, input logic [15:0] dst, input int len);
		csrWrite(cBlkDma, cOfsDmaSrc, 32'(src));
		csrWrite(cBlkDma, cOfsDmaDst, 32'(dst));
		csrWrite(cBlkDma, cOfsDmaLen, 32'(len));
		csrWrite(cBlkDma, cOfsDmaCtrl, 32'h1);
	endtask

	task automatic dmaFinish(input logic [15:0] src, input logic [15:0] dst, input int len);
		int i;
		csrPoll(cBlkDma, cOfsDmaCtrl, 32'h2, 32'h2);	// Done bit
		csrRead("dma status", cBlkDma, cOfsDmaCtrl, 32'h2);	// Done, not busy
		uChk.copyModel(src, dst, len);
		for (i = 0; i < len; i++)
			winRead("dma copy", dst + 16'(i));
	endtask

	// --------------------
	// Tests
	// --------------------
	task automatic testGpio();
		logic [pGpioWidth-1:0] outV, dirV, pinV;
		int                    i;
		for (i = 0; i < 8; i++)
		begin
			outV = pGpioWidth'($random(seed));
			dirV = pGpioWidth'($random(seed));
			uChk.setGpioOut(outV);
			csrWrite(cBlkGpio, cOfsGpioOut, 32'($random(seed)) & ~32'(0) >> 26 << 26 | 32'(outV));
			uChk.setGpioDir(dirV);
			csrWrite(cBlkGpio, cOfsGpioDir, 32'(dirV));
			csrRead("gpio out", cBlkGpio, cOfsGpioOut, 32'(outV));
			csrRead("gpio dir", cBlkGpio, cOfsGpioDir, 32'(dirV));
			pinV = pGpioWidth'($random(seed));
			@(negedge iMCLK);
			gpioIn = pinV;
			repeat (3) @(negedge iMCLK);		// Through the synchroniser
			csrRead("gpio in", cBlkGpio, cOfsGpioIn, 32'(pinV));
		end
	endtask

	task automatic testWindow();
		logic [15:0] known [$];		// Addresses written so far
		logic [15:0] a;
		int          i;
		for (i = 0; i < 12; i++)
		begin
			a = 16'($random(seed));
			winWrite(a, 16'($random(seed)));
			known.push_back(a);
		end
		foreach (known[k])
			winRead("window read", known[k]);
		winRead("window wrap", known[0] + 16'(pRamWords));	// Aliases known[0]
	endtask

	task automatic testDma();
		logic [15:0] src, dst;
		int          len, i;
		src = 16'h0000 + 16'({$random(seed)} % 128);
		dst = 16'h0200 + 16'({$random(seed)} % 128);
		len = 1 + {$random(seed)} % 16;
		for (i = 0; i < len; i++)
			winWrite(src + 16'(i), 16'($random(seed)));
		winWrite(dst - 16'd1, 16'($random(seed)));			// Guard words
		winWrite(dst + 16'(len), 16'($random(seed)));
		dmaStart(src, dst, len);
		dmaFinish(src, dst, len);
		winRead("dma guard low", dst - 16'd1);
		winRead("dma guard high", dst + 16'(len));
	endtask

	// Window traffic while a copy holds the memory bus
	task automatic testContention();
		logic [15:0] src, dst, a;
		int          len, i;
		src = 16'h0100 + 16'({$random(seed)} % 64);
		dst = 16'h0300 + 16'({$random(seed)} % 64);
		len = 8 + {$random(seed)} % 8;
		for (i = 0; i < len; i++)
			winWrite(src + 16'(i), 16'($random(seed)));
		dmaStart(src, dst, len);
		for (i = 0; i < 6; i++)
		begin
			a = 16'hA380 + 16'({$random(seed)} % 128);		// 0x380 to 0x3FF after wrap
			winWrite(a, 16'($random(seed)));
			winRead("contention read", a);
		end
		dmaFinish(src, dst, len);
	endtask

	task automatic testUnmapped();
		logic [3:0] blk;
		int         i;
		for (i = 0; i < 4; i++)
		begin
			blk = 4'(3 + {$random(seed)} % 13);
			csrWrite(blk, 8'h0, 32'($random(seed)));
			csrRead("unmapped block", blk, 8'($random(seed)), 32'h0);
		end
		csrRead("gpio unused", cBlkGpio, 8'h0C, 32'h0);
		csrRead("window unused", cBlkMem, 8'h10, 32'h0);
		csrRead("dma unused", cBlkDma, 8'h10, 32'h0);
	endtask

	initial
	begin
		seed    = 64;
		toutCnt = 0;
		qnARST  = 1'b0;
		usiReq  = 1'b0;
		usiCmd  = '0;
		gpioIn  = '0;
		repeat (8) @(negedge iMCLK);
		qnARST = 1'b1;
		csrRead("window idle after reset", cBlkMem, cOfsMemCmd, 32'h0);
		csrRead("dma idle after reset", cBlkDma, cOfsDmaCtrl, 32'h0);
		testGpio();
		testWindow();
		testDma();
		testContention();
		testUnmapped();
		repeat (4) @(negedge iMCLK);
		$display("Checks %0d, value errors %0d, timeouts %0d, assertion failures %0d",
			uChk.checkCnt, uChk.errCnt, toutCnt, uut.uSva.failCnt);
		if (uChk.errCnt == 0 && toutCnt == 0 && uut.uSva.failCnt == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* dv/k5Soc_sva.sv */
module k5SocSva (
	input logic iMCLK,
	input logic qnARST,
	input logic usiReq,
	input logic usiAck,
	input logic winReq,
	input logic winAck,
	input logic dmaReq,
	input logic dmaAck
);

	timeunit 1ns;
	timeprecision 1ps;

	int failCnt = 0;		// Failed assertions so far

	// Host ack answers a live request only
	usiAckRise: assert property (@(posedge iMCLK) disable iff (!qnARST)
		$rose(usiAck) |-> $past(usiReq))
	else
	begin
		$error("usiAck rose while usiReq was low");
		failCnt++;
	end

	// --------------------
	// Memory bus, per master
	// --------------------
	winAckRise: assert property (@(posedge iMCLK) disable iff (!qnARST)
		$rose(winAck) |-> $past(winReq))
	else
	begin
		$error("Window ack rose while its req was low");
		failCnt++;
	end

	winAckFall: assert property (@(posedge iMCLK) disable iff (!qnARST)
		$fell(winAck) |-> !$past(winReq))		// Held until req drops
	else
	begin
		$error("Window ack fell before its req dropped");
		failCnt++;
	end

	dmaAckRise: assert property (@(posedge iMCLK) disable iff (!qnARST)
		$rose(dmaAck) |-> $past(dmaReq))
	else
	begin
		$error("DMA ack rose while its req was low");
		failCnt++;
	end

	dmaAckFall: assert property (@(posedge iMCLK) disable iff (!qnARST)
		$fell(dmaAck) |-> !$past(dmaReq))
	else
	begin
		$error("DMA ack fell before its req dropped");
		failCnt++;
	end

endmodule

bind k5SocTop k5SocSva uSva (
	.iMCLK(iMCLK),		.qnARST(qnARST),
	.usiReq(usiReq),	.usiAck(usiAck),
	.winReq(winReq),	.winAck(winAck),
	.dmaReq(dmaReq),	.dmaAck(dmaAck)
);

/* flist.f */
verilog/usiPkg.sv
verilog/usiDecoder.sv
verilog/gpioBlock.sv
verilog/memWindow.sv
verilog/copyDma.sv
verilog/ufiMemory.sv
verilog/k5SocTop.sv
dv/k5Soc_sva.sv
dv/k5SocChecker.sv
dv/k5SocTb.sv

/* verilog/copyDma.sv */
module copyDma import usiPkg::*; (
	input  logic        iMCLK,
	input  logic        qnARST,
	input  usiSlvT      slv,
	input  logic        dmaSel,
	output logic [31:0] dmaRd,
	output logic        ufiReq,
	output ufiReqT      ufiCmd,
	input  logic        ufiAck,
	input  logic [15:0] ufiRd
);

	typedef enum logic [1:0] {sIdle, sReq, sDrop} dmaStateT;

	dmaStateT    state;
	logic [15:0] srcQ, dstQ;
	logic [7:0]  lenQ;			// Words, 1 to 255
	logic [7:0]  idxQ;			// Current word
	logic [7:0]  idxNext;
	logic [15:0] dataQ;			// Word in transit
	logic        done, busy;
	ufiReqT      cmdQ;
	logic        csrHit, wrHit, start, lastWord;

	assign csrHit   = slv.stb & dmaSel;
	assign wrHit    = csrHit & slv.wr;
	assign busy     = (state != sIdle);
	assign start    = wrHit && (slv.ofs == cOfsDmaCtrl) && slv.wd[0] && !busy;
	assign idxNext  = idxQ + 8'd1;
	assign lastWord = (idxNext == lenQ);

	// --------------------
	// Copy sequencer
	// --------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			state <= sIdle;
			done  <= 1'b0;
			idxQ  <= '0;
		end
		else
		begin
			case (state)
				sIdle:
					if (start)
					begin
						done  <= 1'b0;
						idxQ  <= '0;
						state <= sReq;		// First read
					end
				sReq:
					if (ufiAck)
						state <= sDrop;
				sDrop:
					if (!ufiAck)
					begin
						if (!cmdQ.wr)
							state <= sReq;		// Read done, go write
						else if (lastWord)
						begin
							done  <= 1'b1;
							state <= sIdle;
						end
						else
						begin
							idxQ  <= idxNext;
							state <= sReq;
						end
					end
				default: state <= sIdle;
			endcase
		end
	end

	// Bus command and CSR side
	always_ff @(posedge iMCLK)
	begin
		if (start)
			cmdQ <= '{wr: 1'b0, adrs: srcQ, wd: 16'h0};
		else if (state == sDrop && !ufiAck)
		begin
			if (!cmdQ.wr)
				cmdQ <= '{wr: 1'b1, adrs: dstQ + 16'(idxQ), wd: dataQ};
			else
				cmdQ <= '{wr: 1'b0, adrs: srcQ + 16'(idxNext), wd: 16'h0};
		end
		if (state == sReq && ufiAck && !cmdQ.wr)
			dataQ <= ufiRd;
		if (wrHit && !busy)		// Setup frozen during a copy
		begin
			case (slv.ofs)
				cOfsDmaSrc: srcQ <= slv.wd[15:0];
				cOfsDmaDst: dstQ <= slv.wd[15:0];
				cOfsDmaLen: lenQ <= slv.wd[7:0];
				default: ;
			endcase
		end
		if (csrHit)
		begin
			case (slv.ofs)
				cOfsDmaSrc:  dmaRd <= 32'(srcQ);
				cOfsDmaDst:  dmaRd <= 32'(dstQ);
				cOfsDmaLen:  dmaRd <= 32'(lenQ);
				cOfsDmaCtrl: dmaRd <= {29'b0, busy, done, 1'b0};	// Start reads 0
				default:     dmaRd <= '0;
			endcase
		end
	end

	assign ufiReq = (state == sReq);
	assign ufiCmd = cmdQ;

endmodule

/* verilog/gpioBlock.sv */
module gpioBlock import usiPkg::*; #(
	parameter int pGpioWidth = 6
) (
	input  logic                  iMCLK,
	input  logic                  qnARST,
	input  usiSlvT                slv,
	input  logic                  gpioSel,
	output logic [31:0]           gpioRd,
	input  logic [pGpioWidth-1:0] gpioIn,
	output logic [pGpioWidth-1:0] gpioOut,
	output logic [pGpioWidth-1:0] gpioOe
);

	logic [pGpioWidth-1:0] outQ, dirQ;
	logic [pGpioWidth-1:0] syncA, syncB;	// Pin synchroniser
	logic                  csrHit;

	assign csrHit = slv.stb & gpioSel;

	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			outQ  <= '0;
			dirQ  <= '0;		// All pins input
			syncA <= '0;
			syncB <= '0;
		end
		else
		begin
			syncA <= gpioIn;
			syncB <= syncA;
			if (csrHit && slv.wr)
			begin
				case (slv.ofs)
					cOfsGpioOut: outQ <= slv.wd[pGpioWidth-1:0];
					cOfsGpioDir: dirQ <= slv.wd[pGpioWidth-1:0];
					default: ;		// GpioIn is read only
				endcase
			end
		end
	end

	// Read data one cycle after the strobe
	always_ff @(posedge iMCLK)
	begin
		if (csrHit)
		begin
			case (slv.ofs)
				cOfsGpioOut: gpioRd <= 32'(outQ);
				cOfsGpioDir: gpioRd <= 32'(dirQ);
				cOfsGpioIn:  gpioRd <= 32'(syncB);
				default:     gpioRd <= '0;
			endcase
		end
	end

	assign gpioOut = outQ;
	assign gpioOe  = dirQ;		// 1 = drive

endmodule

/* verilog/k5SocTop.sv */
module k5SocTop import usiPkg::*; #(
	parameter int pGpioWidth = 6,		// LED pins
	parameter int pRamWords  = 1024		// Shared RAM depth
) (
	input  logic                  iMCLK,
	input  logic                  qnARST,
	// Host port
	input  logic                  usiReq,
	input  usiCmdT                usiCmd,
	output logic                  usiAck,
	output logic [31:0]           usiRd,
	// Pins
	input  logic [pGpioWidth-1:0] gpioIn,
	output logic [pGpioWidth-1:0] gpioOut,
	output logic [pGpioWidth-1:0] gpioOe
);

	// --------------------
	// CSR bus
	// --------------------
	usiSlvT      slv;
	logic        gpioSel, memSel, dmaSel;
	logic [31:0] gpioRd, memRd, dmaRd;

	// --------------------
	// Memory bus
	// --------------------
	logic        winReq, winAck;		// Master 0
	ufiReqT      winCmd;
	logic [15:0] winRd;
	logic        dmaReq, dmaAck;		// Master 1
	ufiReqT      dmaCmd;
	logic [15:0] dmaUfiRd;

	usiDecoder uDecoder (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.usiReq(usiReq),	.usiCmd(usiCmd),
		.usiAck(usiAck),	.usiRd(usiRd),
		.slv(slv),
		.gpioSel(gpioSel),	.memSel(memSel),	.dmaSel(dmaSel),
		.gpioRd(gpioRd),	.memRd(memRd),		.dmaRd(dmaRd)
	);

	gpioBlock #(.pGpioWidth(pGpioWidth)) uGpio (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.slv(slv),			.gpioSel(gpioSel),	.gpioRd(gpioRd),
		.gpioIn(gpioIn),	.gpioOut(gpioOut),	.gpioOe(gpioOe)
	);

	memWindow uWindow (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.slv(slv),			.memSel(memSel),	.memRd(memRd),
		.ufiReq(winReq),	.ufiCmd(winCmd),
		.ufiAck(winAck),	.ufiRd(winRd)
	);

	copyDma uDma (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.slv(slv),			.dmaSel(dmaSel),	.dmaRd(dmaRd),
		.ufiReq(dmaReq),	.ufiCmd(dmaCmd),
		.ufiAck(dmaAck),	.ufiRd(dmaUfiRd)
	);

	ufiMemory #(.pRamWords(pRamWords)) uMemory (
		.iMCLK(iMCLK),		.qnARST(qnARST),
		.req0(winReq),		.cmd0(winCmd),		.ack0(winAck),	.rd0(winRd),
		.req1(dmaReq),		.cmd1(dmaCmd),		.ack1(dmaAck),	.rd1(dmaUfiRd)
	);

endmodule

/* verilog/memWindow.sv */
module memWindow import usiPkg::*; (
	input  logic        iMCLK,
	input  logic        qnARST,
	input  usiSlvT      slv,
	input  logic        memSel,
	output logic [31:0] memRd,
	output logic        ufiReq,
	output ufiReqT      ufiCmd,
	input  logic        ufiAck,
	input  logic [15:0] ufiRd
);

	logic [15:0] adrsQ, wdQ;
	logic [15:0] rdQ;			// Last read result
	logic        busy;
	ufiReqT      cmdQ;			// Held for the whole bus cycle
	logic        csrHit, wrHit, start;

	assign csrHit = slv.stb & memSel;
	assign wrHit  = csrHit & slv.wr;
	// Bit 0 write, bit 1 read, ignored while busy
	assign start  = wrHit && (slv.ofs == cOfsMemCmd) && !busy
		&& (slv.wd[0] || slv.wd[1]);

	// --------------------
	// Master side four-phase
	// --------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			busy   <= 1'b0;
			ufiReq <= 1'b0;
		end
		else if (start)
		begin
			busy   <= 1'b1;
			ufiReq <= 1'b1;
		end
		else if (ufiReq && ufiAck)
			ufiReq <= 1'b0;			// Data taken, release
		else if (busy && !ufiReq && !ufiAck)
			busy   <= 1'b0;			// Ack gone, cycle done
	end

	always_ff @(posedge iMCLK)
	begin
		if (wrHit && slv.ofs == cOfsMemAdrs)
			adrsQ <= slv.wd[15:0];
		if (wrHit && slv.ofs == cOfsMemWd)
			wdQ <= slv.wd[15:0];
		if (start)
			cmdQ <= '{wr: slv.wd[0], adrs: adrsQ, wd: wdQ};	// Write wins if both
		if (ufiReq && ufiAck && !cmdQ.wr)
			rdQ <= ufiRd;
		if (csrHit)
		begin
			case (slv.ofs)
				cOfsMemAdrs: memRd <= 32'(adrsQ);
				cOfsMemWd:   memRd <= 32'(wdQ);
				cOfsMemCmd:  memRd <= {busy, 31'b0};	// Busy at bit 31
				cOfsMemRd:   memRd <= 32'(rdQ);
				default:     memRd <= '0;
			endcase
		end
	end

	assign ufiCmd = cmdQ;

endmodule

/* verilog/ufiMemory.sv */
module ufiMemory import usiPkg::*; #(
	parameter int pRamWords = 1024
) (
	input  logic        iMCLK,
	input  logic        qnARST,
	input  logic        req0,		// Window
	input  logic        req1,		// DMA
	input  ufiReqT      cmd0,
	input  ufiReqT      cmd1,
	output logic        ack0,
	output logic        ack1,
	output logic [15:0] rd0,
	output logic [15:0] rd1
);

	localparam int lpAw = $clog2(pRamWords);

	typedef enum logic [1:0] {sIdle, sRam, sAck, sHold} arbStateT;

	arbStateT    state;
	logic        gntQ;			// Granted master, also last winner
	logic [1:0]  ackQ;
	logic        pick;
	logic        reqGnt;
	ufiReqT      cmdSel;
	logic [lpAw-1:0] ramIdx;
	logic [15:0] ram [pRamWords];
	logic [15:0] ramQ;

	// Tie goes to the master that did not win last
	assign pick   = (req0 && req1) ? ~gntQ : req1;
	assign reqGnt = gntQ ? req1 : req0;
	assign cmdSel = gntQ ? cmd1 : cmd0;
	assign ramIdx = lpAw'(cmdSel.adrs % 16'(pRamWords));	// Wraps

	// --------------------
	// Arbiter
	// --------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			state <= sIdle;
			gntQ  <= 1'b1;		// Master 0 wins first tie
			ackQ  <= '0;
		end
		else
		begin
			case (state)
				sIdle:
					if (req0 || req1)
					begin
						gntQ  <= pick;
						state <= sRam;
					end
				sRam:
					state <= sAck;		// RAM access this edge
				sAck:
				begin
					ackQ[gntQ] <= 1'b1;
					state      <= sHold;
				end
				sHold:
					if (!reqGnt)
					begin
						ackQ  <= '0;		// Master released
						state <= sIdle;
					end
				default: state <= sIdle;
			endcase
		end
	end

	// Single-port synchronous RAM
	always_ff @(posedge iMCLK)
	begin
		if (state == sRam)
		begin
			if (cmdSel.wr)
				ram[ramIdx] <= cmdSel.wd;
			else
				ramQ <= ram[ramIdx];
		end
	end

	assign ack0 = ackQ[0];
	assign ack1 = ackQ[1];
	assign rd0  = ramQ;		// Valid while ack high
	assign rd1  = ramQ;

endmodule

/* verilog/usiDecoder.sv */
module usiDecoder import usiPkg::*; (
	input  logic        iMCLK,
	input  logic        qnARST,
	input  logic        usiReq,
	input  usiCmdT      usiCmd,
	output logic        usiAck,
	output logic [31:0] usiRd,
	output usiSlvT      slv,
	output logic        gpioSel,
	output logic        memSel,
	output logic        dmaSel,
	input  logic [31:0] gpioRd,
	input  logic [31:0] memRd,
	input  logic [31:0] dmaRd
);

	logic        reqQ;			// Sampled host request
	logic        active;		// Access in flight until ack drops
	logic        stbQ;			// Strobe stage
	logic        rdPend;		// Block register stage
	logic [2:0]  selD, selQ;	// {dma, mem, gpio}
	logic [3:0]  blkQ;			// Kept for read-data return
	logic        wrQ;
	logic [7:0]  ofsQ;
	logic [31:0] wdQ;
	logic        newReq;

	assign newReq = reqQ & ~active;

	// Block field to one-hot select
	always_comb
	begin
		case (usiCmd.adrs.fld.blk)
			cBlkGpio: selD = 3'b001;
			cBlkMem:  selD = 3'b010;
			cBlkDma:  selD = 3'b100;
			default:  selD = 3'b000;	// Unmapped, no block answers
		endcase
	end

	// --------------------
	// Handshake sequence
	// --------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			reqQ   <= 1'b0;
			active <= 1'b0;
			stbQ   <= 1'b0;
			rdPend <= 1'b0;
			selQ   <= '0;
			usiAck <= 1'b0;
		end
		else
		begin
			reqQ   <= usiReq;
			stbQ   <= newReq;				// One-cycle strobe
			rdPend <= stbQ;					// Block registers its data here
			selQ   <= newReq ? selD : 3'b000;
			if (newReq)
				active <= 1'b1;
			else if (usiAck && !reqQ)
				active <= 1'b0;			// Four-phase complete
			if (rdPend)
				usiAck <= 1'b1;
			else if (usiAck && !reqQ)
				usiAck <= 1'b0;
		end
	end

	// Command payload and read return
	always_ff @(posedge iMCLK)
	begin
		if (newReq)
		begin
			blkQ <= usiCmd.adrs.fld.blk;
			wrQ  <= usiCmd.wr;
			ofsQ <= usiCmd.adrs.fld.ofs;
			wdQ  <= usiCmd.wd;
		end
		if (rdPend)
		begin
			case (blkQ)
				cBlkGpio: usiRd <= gpioRd;
				cBlkMem:  usiRd <= memRd;
				cBlkDma:  usiRd <= dmaRd;
				default:  usiRd <= '0;
			endcase
		end
	end

	assign slv = '{stb: stbQ, wr: wrQ, ofs: ofsQ, wd: wdQ};
	assign {dmaSel, memSel, gpioSel} = selQ;

endmodule

/* verilog/usiPkg.sv */
package usiPkg;

	// --------------------
	// CSR bus types
	// --------------------

	// Address word split into block and byte offset
	typedef struct packed {
		logic [3:0] blk;		// Block select, top nibble
		logic [3:0] rsv;		// Reserved
		logic [7:0] ofs;		// Byte offset inside the block
	} usiAdrsFldT;

	// Decoder looks at blk, the blocks look at ofs
	typedef union packed {
		logic [15:0] flat;
		usiAdrsFldT  fld;
	} usiAdrsT;

	// Host command
	typedef struct packed {
		logic        wr;		// 1 = write
		usiAdrsT     adrs;
		logic [31:0] wd;
	} usiCmdT;

	// Decoder to block strobe
	typedef struct packed {
		logic        stb;		// One cycle per access
		logic        wr;
		logic [7:0]  ofs;
		logic [31:0] wd;
	} usiSlvT;

	// --------------------
	// Memory bus types
	// --------------------
	typedef struct packed {
		logic        wr;
		logic [15:0] adrs;		// Word address
		logic [15:0] wd;
	} ufiReqT;

	// Block map, other values unmapped
	localparam logic [3:0] cBlkGpio = 4'h0;
	localparam logic [3:0] cBlkMem  = 4'h1;
	localparam logic [3:0] cBlkDma  = 4'h2;

	// Register offsets
	localparam logic [7:0] cOfsGpioOut = 8'h0;
	localparam logic [7:0] cOfsGpioDir = 8'h4;
	localparam logic [7:0] cOfsGpioIn  = 8'h8;
	localparam logic [7:0] cOfsMemAdrs = 8'h0;
	localparam logic [7:0] cOfsMemWd   = 8'h4;
	localparam logic [7:0] cOfsMemCmd  = 8'h8;
	localparam logic [7:0] cOfsMemRd   = 8'hC;
	localparam logic [7:0] cOfsDmaSrc  = 8'h0;
	localparam logic [7:0] cOfsDmaDst  = 8'h4;
	localparam logic [7:0] cOfsDmaLen  = 8'h8;
	localparam logic [7:0] cOfsDmaCtrl = 8'hC;

endpackage
